/* logic/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// ==========================================================
// DMA subsystem sizes
// ==========================================================

// Channel count and the width of a channel number
`define DMA_CHANNELS 4
`define DMA_CHAN_W 2

// Channel address and count width, page width on top of it
`define DMA_ADDR_W 16
`define DMA_PAGE_W 4
`define DMA_MEM_ADDR_W (`DMA_ADDR_W + `DMA_PAGE_W)

// Word width of the memory and device data paths
`define DMA_DATA_W 16

// Memory port queue depth, also the engine credit count
`define DMA_MEM_CREDITS 2

`endif

/* logic/dma_pkg.sv */
`include "dma_params.svh"

package dma_pkg;

    // ==========================================================
    // Control word, CPU write with cpu_addr[4] high
    // ==========================================================

    // Mode view, cpu_addr[1] low
    typedef struct packed {
        logic [2:0]                 reserved;
        logic                       decrement;   // address counts down
        logic                       auto_init;   // reload base at terminal count
        logic                       to_memory;   // device to memory when set
        logic [`DMA_CHAN_W-1:0]     channel;
    } dma_mode_view_t;

    // Single channel mask view, cpu_addr[1] high
    typedef struct packed {
        logic [4:0]                 reserved;
        logic                       mask_set;
        logic [`DMA_CHAN_W-1:0]     channel;
    } dma_mask_view_t;

    // Same byte, decoded by register address
    typedef union packed {
        dma_mode_view_t mode;
        dma_mask_view_t mask;
    } dma_ctrl_word_u;

    // ==========================================================
    // Engine to memory port request
    // ==========================================================

    typedef struct packed {
        logic [`DMA_MEM_ADDR_W-1:0] addr;    // page then channel address
        logic                       write;   // device to memory
        logic [`DMA_DATA_W-1:0]     wdata;
        logic [`DMA_CHAN_W-1:0]     chan;    // tags the read completion
    } dma_mem_req_t;

endpackage

/* logic/dma_mem_if.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

interface dma_mem_if;
    import dma_pkg::*;

    // Request, one cycle per transfer, only with a credit held
    logic                       req_valid;
    dma_mem_req_t               req;

    // One pulse per request leaving the port queue
    logic                       credit_return;

    // Read completion
    logic                       rsp_valid;
    logic [`DMA_DATA_W-1:0]     rsp_data;
    logic [`DMA_CHAN_W-1:0]     rsp_chan;

    modport engine (output req_valid, req, input credit_return);

    modport port (input req_valid, req,
                  output credit_return, rsp_valid, rsp_data, rsp_chan);

endinterface

/* logic/dma_channel_regs.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_channel_regs (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        cpu_sel_dma,
    input  logic                                        cpu_sel_page,
    input  logic                                        cpu_access,
    input  logic                                        cpu_wr,
    input  logic [4:0]                                  cpu_addr,
    input  logic [`DMA_DATA_W-1:0]                      cpu_data,
    output logic                                        cpu_ack,
    input  logic                                        step,
    input  logic [`DMA_CHAN_W-1:0]                      step_chan,
    output logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]   cur_addr,
    output logic [`DMA_CHANNELS-1:0][`DMA_PAGE_W-1:0]   page,
    output logic [`DMA_CHANNELS-1:0]                    to_memory,
    output logic [`DMA_CHANNELS-1:0]                    decrement,
    output logic [`DMA_CHANNELS-1:0]                    mask,
    output logic [`DMA_CHANNELS-1:0]                    last
);
    import dma_pkg::*;

    logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]  base_addr;
    logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]  base_count;
    logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]  cur_count;
    logic [`DMA_CHANNELS-1:0]                   auto_init;

    // One-hot write strobes per channel
    logic [`DMA_CHANNELS-1:0]   addr_wr;
    logic [`DMA_CHANNELS-1:0]   count_wr;
    logic [`DMA_CHANNELS-1:0]   mode_wr;
    logic [`DMA_CHANNELS-1:0]   mask_wr;
    logic [`DMA_CHANNELS-1:0]   page_wr;
    logic [`DMA_CHANNELS-1:0]   step_sel;
    logic                       wr_en;
    dma_ctrl_word_u             ctrl;

    assign wr_en = cpu_access & cpu_wr;
    assign ctrl  = cpu_data[7:0];

    // ==========================================================
    // CPU write decode
    // ==========================================================
    always_comb begin
        addr_wr  = '0;
        count_wr = '0;
        mode_wr  = '0;
        mask_wr  = '0;
        page_wr  = '0;
        step_sel = '0;
        step_sel[step_chan] = step;
        // Channel address or count, cpu_addr[2:1] is the channel
        if (wr_en && cpu_sel_dma && !cpu_addr[4]) begin
            if (cpu_addr[3])
                count_wr[cpu_addr[2:1]] = 1'b1;
            else
                addr_wr[cpu_addr[2:1]] = 1'b1;
        end
        // Control byte carries its own channel number
        if (wr_en && cpu_sel_dma && cpu_addr[4]) begin
            if (cpu_addr[1])
                mask_wr[ctrl.mask.channel] = 1'b1;
            else
                mode_wr[ctrl.mode.channel] = 1'b1;
        end
        if (wr_en && cpu_sel_page)
            page_wr[cpu_addr[2:1]] = 1'b1;
    end

    // Count of zero means the next transfer is the final one
    always_comb begin
        for (int ch = 0; ch < `DMA_CHANNELS; ch++)
            last[ch] = (cur_count[ch] == '0);
    end

    // ==========================================================
    // Channel state
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cpu_ack    <= 1'b0;
            base_addr  <= '0;
            base_count <= '0;
            cur_addr   <= '0;
            cur_count  <= '0;
            page       <= '0;
            to_memory  <= '0;
            auto_init  <= '0;
            decrement  <= '0;
            // Nothing runs until the CPU clears a mask
            mask       <= '1;
        end else begin
            cpu_ack <= (cpu_sel_dma | cpu_sel_page) & cpu_access;
            for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
                // Engine step, applied in the acknowledge cycle
                if (step_sel[ch]) begin
                    if (last[ch]) begin
                        if (auto_init[ch]) begin
                            cur_addr[ch]  <= base_addr[ch];
                            cur_count[ch] <= base_count[ch];
                        end else begin
                            mask[ch] <= 1'b1;
                        end
                    end else begin
                        if (decrement[ch])
                            cur_addr[ch] <= cur_addr[ch] - 1'b1;
                        else
                            cur_addr[ch] <= cur_addr[ch] + 1'b1;
                        cur_count[ch] <= cur_count[ch] - 1'b1;
                    end
                end
                // CPU writes win over a step in the same cycle
                if (addr_wr[ch]) begin
                    base_addr[ch] <= cpu_data;
                    cur_addr[ch]  <= cpu_data;
                end
                if (count_wr[ch]) begin
                    base_count[ch] <= cpu_data;
                    cur_count[ch]  <= cpu_data;
                end
                if (mode_wr[ch]) begin
                    to_memory[ch] <= ctrl.mode.to_memory;
                    auto_init[ch] <= ctrl.mode.auto_init;
                    decrement[ch] <= ctrl.mode.decrement;
                end
                if (mask_wr[ch])
                    mask[ch] <= ctrl.mask.mask_set;
                if (page_wr[ch])
                    page[ch] <= cpu_data[`DMA_PAGE_W-1:0];
            end
        end
    end

endmodule

/* logic/dma_transfer_engine.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_transfer_engine (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [`DMA_CHANNELS-1:0]                    dma_req,
    input  logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]   cur_addr,
    input  logic [`DMA_CHANNELS-1:0][`DMA_PAGE_W-1:0]   page,
    input  logic [`DMA_CHANNELS-1:0]                    to_memory,
    input  logic [`DMA_CHANNELS-1:0]                    mask,
    input  logic [`DMA_CHANNELS-1:0]                    last,
    input  logic [`DMA_DATA_W-1:0]                      dev_wdata,
    output logic                                        step,
    output logic [`DMA_CHAN_W-1:0]                      step_chan,
    output logic [`DMA_CHANNELS-1:0]                    dma_ack,
    output logic                                        tc,
    dma_mem_if.engine                                   mem
);
    import dma_pkg::*;

    localparam int CHAN_W = `DMA_CHAN_W;
    localparam int CRED_W = $clog2(`DMA_MEM_CREDITS + 1);

    logic [CRED_W-1:0]          credits;
    logic                       grant_valid;
    logic [CHAN_W-1:0]          grant_chan;
    logic                       issue;
    logic [`DMA_CHANNELS-1:0]   ack_next;
    dma_mem_req_t               next_req;

    // ==========================================================
    // Fixed priority, channel 0 highest
    // ==========================================================
    always_comb begin
        grant_valid = 1'b0;
        grant_chan  = '0;
        // Walk down so the lowest requesting channel is kept
        for (int ch = `DMA_CHANNELS - 1; ch >= 0; ch--) begin
            if (dma_req[ch] && !mask[ch]) begin
                grant_valid = 1'b1;
                grant_chan  = CHAN_W'(ch);
            end
        end
    end

    // step high marks the acknowledge cycle, no issue there
    assign issue = grant_valid && !step && (credits != '0);

    always_comb begin
        ack_next = '0;
        ack_next[grant_chan] = issue;
    end

    // Word address is the page above the channel address
    always_comb begin
        next_req.addr  = {page[grant_chan], cur_addr[grant_chan]};
        next_req.write = to_memory[grant_chan];
        next_req.wdata = dev_wdata;
        next_req.chan  = grant_chan;
    end

    // ==========================================================
    // Credit counter
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= CRED_W'(`DMA_MEM_CREDITS);
        end else begin
            case ({issue, mem.credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ==========================================================
    // Issue registers
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem.req_valid <= 1'b0;
            step          <= 1'b0;
            dma_ack       <= '0;
            tc            <= 1'b0;
        end else begin
            mem.req_valid <= issue;
            step          <= issue;
            dma_ack       <= ack_next;
            // Terminal count rides with the final acknowledge
            tc            <= issue & last[grant_chan];
        end
    end

    // Payload, only meaningful with req_valid or step
    always_ff @(posedge clk) begin
        if (issue) begin
            mem.req   <= next_req;
            step_chan <= grant_chan;
        end
    end

endmodule

/* logic/dma_mem_port.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_mem_port (
    input  logic                        clk,
    input  logic                        reset,
    dma_mem_if.port                     mem,
    output logic [`DMA_MEM_ADDR_W-1:0]  m_addr,
    output logic                        m_wr,
    output logic                        m_access,
    output logic [`DMA_DATA_W-1:0]      m_wdata,
    input  logic [`DMA_DATA_W-1:0]      m_rdata,
    input  logic                        m_ack
);
    import dma_pkg::*;

    localparam int DEPTH = `DMA_MEM_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dma_mem_req_t       queue [DEPTH];
    dma_mem_req_t       head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   used;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head entry sits on the bus until the memory acknowledges
    assign head     = queue[rd_ptr];
    assign m_access = (used != '0);
    assign m_addr   = head.addr;
    assign m_wr     = head.write;
    assign m_wdata  = head.wdata;

    // A pop frees a slot, hand the credit back at once
    assign pop               = m_access & m_ack;
    assign mem.credit_return = pop;

    // ==========================================================
    // In-order queue, never full thanks to engine credits
    // ==========================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (mem.req_valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            case ({mem.req_valid, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req_valid)
            queue[wr_ptr] <= mem.req;
    end

    // Read completion, one cycle behind m_ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            mem.rsp_valid <= 1'b0;
        else
            mem.rsp_valid <= pop & ~head.write;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            mem.rsp_data <= m_rdata;
            mem.rsp_chan <= head.chan;
        end
    end

endmodule

/* logic/dma_unit.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_unit (
    input  logic                        clk,
    input  logic                        reset,
    // CPU register write port
    input  logic                        cpu_sel_dma,
    input  logic                        cpu_sel_page,
    input  logic                        cpu_access,
    input  logic                        cpu_wr,
    input  logic [4:0]                  cpu_addr,
    input  logic [`DMA_DATA_W-1:0]      cpu_data,
    output logic                        cpu_ack,
    // Device handshake
    input  logic [`DMA_CHANNELS-1:0]    dma_req,
    output logic [`DMA_CHANNELS-1:0]    dma_ack,
    output logic                        tc,
    input  logic [`DMA_DATA_W-1:0]      dev_wdata,
    output logic [`DMA_DATA_W-1:0]      dev_rdata,
    output logic                        dev_rvalid,
    output logic [`DMA_CHAN_W-1:0]      dev_rchan,
    // Memory bus
    output logic [`DMA_MEM_ADDR_W-1:0]  m_addr,
    output logic                        m_wr,
    output logic [`DMA_DATA_W-1:0]      m_wdata,
    input  logic [`DMA_DATA_W-1:0]      m_rdata,
    output logic                        m_access,
    input  logic                        m_ack
);

    // ==========================================================
    // Register file to engine
    // ==========================================================
    logic [`DMA_CHANNELS-1:0][`DMA_ADDR_W-1:0]  cur_addr;
    logic [`DMA_CHANNELS-1:0][`DMA_PAGE_W-1:0]  page;
    logic [`DMA_CHANNELS-1:0]                   to_memory;
    logic [`DMA_CHANNELS-1:0]                   mask;
    logic [`DMA_CHANNELS-1:0]                   last;
    logic                                       step;
    logic [`DMA_CHAN_W-1:0]                     step_chan;

    dma_mem_if mem_bus ();

    dma_channel_regs u_regs (
        .clk, .reset,
        .cpu_sel_dma, .cpu_sel_page, .cpu_access, .cpu_wr,
        .cpu_addr, .cpu_data, .cpu_ack,
        .step, .step_chan,
        .cur_addr, .page, .to_memory, .decrement (), .mask, .last
    );

    dma_transfer_engine u_engine (
        .clk, .reset,
        .dma_req, .cur_addr, .page, .to_memory, .mask, .last, .dev_wdata,
        .step, .step_chan, .dma_ack, .tc,
        .mem (mem_bus.engine)
    );

    dma_mem_port u_mem_port (
        .clk, .reset,
        .mem (mem_bus.port),
        .m_addr, .m_wr, .m_access, .m_wdata, .m_rdata, .m_ack
    );

    // Read data goes straight back to the devices
    assign dev_rvalid = mem_bus.rsp_valid;
    assign dev_rdata  = mem_bus.rsp_data;
    assign dev_rchan  = mem_bus.rsp_chan;

endmodule

/* tests/dma_unit_checker.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_unit_checker (
    input logic                         clk,
    input logic                         reset,
    input logic [`DMA_CHANNELS-1:0]     dma_ack,
    input logic                         tc,
    input logic                         m_access,
    input logic                         m_ack,
    input logic [`DMA_MEM_ADDR_W-1:0]   m_addr,
    input logic                         m_wr,
    input logic [`DMA_DATA_W-1:0]       m_wdata
);

    // Issued minus completed bus requests
    logic [3:0] in_flight;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            in_flight <= '0;
        else
            in_flight <= in_flight + 4'(|dma_ack) - 4'(m_access & m_ack);
    end

    // ==========================================================
    // Protocol properties
    // ==========================================================
    a_ack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(dma_ack))
        else $error("dma_ack has more than one channel set");

    // Terminal count only with the final acknowledge
    a_tc_with_ack: assert property (@(posedge clk) disable iff (reset) tc |-> (dma_ack != '0))
        else $error("tc high without dma_ack");

    a_access_hold: assert property (@(posedge clk) disable iff (reset)
        (m_access && !m_ack) |=> (m_access && $stable(m_addr) && $stable(m_wr) && $stable(m_wdata)))
        else $error("memory request changed or dropped before m_ack");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        in_flight <= 4'(`DMA_MEM_CREDITS))
        else $error("requests in flight exceed the memory credits");

endmodule

bind dma_unit dma_unit_checker u_checker (.*);

/* tests/dma_unit_tb.sv */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_unit_tb;

    localparam int          TIMEOUT = 4000;
    localparam logic [15:0] RD_KEY  = 16'h5A3C;

    logic        clk;
    logic        reset;
    logic        cpu_sel_dma, cpu_sel_page, cpu_access, cpu_wr;
    logic [4:0]  cpu_addr;
    logic [15:0] cpu_data;
    logic        cpu_ack;
    logic [3:0]  dma_req, dma_ack;
    logic        tc;
    logic [15:0] dev_wdata, dev_rdata;
    logic        dev_rvalid;
    logic [1:0]  dev_rchan;
    logic [19:0] m_addr;
    logic        m_wr, m_access, m_ack;
    logic [15:0] m_wdata, m_rdata;

    // Reference copy of the programmed channel state
    logic [3:0][15:0] mdl_base_addr, mdl_base_count, mdl_cur, mdl_count;
    logic [3:0][3:0]  mdl_page;
    logic [3:0]       mdl_to_mem, mdl_auto, mdl_dec, mdl_mask;
    int               xfers [4];

    // Expected bus requests {page, addr, write, wdata, chan} and reads {chan, data}
    logic [38:0] req_q [$];
    logic [17:0] rd_q [$];

    // High in the cycle after a selected CPU access
    logic        ack_due;

    logic [3:0]  dev_on;
    logic [7:0]  lfsr;
    logic        bus_busy;
    logic [19:0] bus_addr;
    int          bus_wait;
    int          in_flight;
    int          cycles;

    dma_unit u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // Two LFSR bits give 0 to 3 idle cycles
    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ==========================================================
    // Per-cycle checks, run at the falling edge
    // ==========================================================
    task automatic check_cpu_ack();
        assert (cpu_ack == ack_due)
            else report_error($sformatf("cpu_ack %b, expected %b", cpu_ack, ack_due));
    endtask

    task automatic check_grant();
        logic [3:0] want;
        int         ch;
        want = '0;
        ch   = 0;
        // Lowest unmasked requester wins
        for (int c = 3; c >= 0; c--)
            if (dma_req[c] && !mdl_mask[c])
                want = 4'b0001 << c;
        if (dma_ack == '0) begin
            assert (!tc) else report_error("tc high without dma_ack");
        end else begin
            assert (dma_ack == want)
                else report_error($sformatf("dma_ack %b, expected %b", dma_ack, want));
            for (int c = 0; c < 4; c++)
                if (dma_ack[c])
                    ch = c;
            assert (tc == (mdl_count[ch] == 16'd0))
                else report_error($sformatf("tc %b on channel %0d", tc, ch));
            req_q.push_back({mdl_page[ch], mdl_cur[ch], mdl_to_mem[ch], dev_wdata, 2'(ch)});
            xfers[ch]++;
            in_flight++;
            assert (in_flight <= `DMA_MEM_CREDITS)
                else report_error("more requests in flight than credits");
            // Step, then reload or self-mask at terminal count
            if (mdl_count[ch] == 16'd0) begin
                if (mdl_auto[ch]) begin
                    mdl_cur[ch]   = mdl_base_addr[ch];
                    mdl_count[ch] = mdl_base_count[ch];
                end else begin
                    mdl_mask[ch] = 1'b1;
                end
            end else begin
                mdl_cur[ch]   = mdl_dec[ch] ? mdl_cur[ch] - 16'd1 : mdl_cur[ch] + 16'd1;
                mdl_count[ch] = mdl_count[ch] - 16'd1;
            end
        end
    endtask

    // Memory model with random latency, and read completion checks
    task automatic run_memory();
        logic [38:0] want_req;
        logic [17:0] want_rd;
        if (dev_rvalid) begin
            assert (rd_q.size() != 0) else report_error("dev_rvalid with no read outstanding");
            want_rd = rd_q.pop_front();
            assert (dev_rchan == want_rd[17:16] && dev_rdata == want_rd[15:0])
                else report_error($sformatf("read ch %0d data %h, expected ch %0d data %h",
                                            dev_rchan, dev_rdata, want_rd[17:16], want_rd[15:0]));
        end
        if (m_ack) begin
            m_ack = 1'b0;
            in_flight--;
        end else if (m_access) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                bus_addr = m_addr;
                draw_delay(bus_wait);
            end
            assert (m_addr == bus_addr) else report_error("m_addr changed before m_ack");
            if (bus_wait == 0) begin
                assert (req_q.size() != 0) else report_error("m_access with no transfer issued");
                want_req = req_q.pop_front();
                assert (m_addr == want_req[38:19])
                    else report_error($sformatf("m_addr %h, expected %h", m_addr, want_req[38:19]));
                assert (m_wr == want_req[18])
                    else report_error($sformatf("m_wr %b at %h", m_wr, m_addr));
                if (want_req[18]) begin
                    assert (m_wdata == want_req[17:2])
                        else report_error($sformatf("m_wdata %h, expected %h", m_wdata, want_req[17:2]));
                end else begin
                    rd_q.push_back({want_req[1:0], want_req[34:19] ^ RD_KEY});
                end
                m_rdata  = m_addr[15:0] ^ RD_KEY;
                m_ack    = 1'b1;
                bus_busy = 1'b0;
            end else begin
                bus_wait--;
            end
        end else begin
            assert (!bus_busy) else report_error("m_access dropped before m_ack");
        end
    endtask

    // Devices drop a request for the cycle after their acknowledge
    task automatic drive_devices();
        for (int c = 0; c < 4; c++)
            dma_req[c] = dev_on[c] && !dma_ack[c];
        dev_wdata = 16'hC000 ^ 16'(cycles * 7);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Finished with errors");
            $fatal(1, "Timeout: transfers did not complete within %0d cycles", TIMEOUT);
        end
        check_cpu_ack();
        check_grant();
        run_memory();
        drive_devices();
    endtask

    // ==========================================================
    // CPU programming
    // ==========================================================
    task automatic cpu_write(input logic sel_dma, input logic [4:0] addr, input logic [15:0] data);
        next_cycle();
        cpu_sel_dma  = sel_dma;
        cpu_sel_page = !sel_dma;
        cpu_access   = 1'b1;
        cpu_wr       = 1'b1;
        cpu_addr     = addr;
        cpu_data     = data;
        ack_due      = 1'b1;
        next_cycle();
        cpu_sel_dma  = 1'b0;
        cpu_sel_page = 1'b0;
        cpu_access   = 1'b0;
        cpu_wr       = 1'b0;
        ack_due      = 1'b0;
        // Write has landed, mirror it into the model
        if (!sel_dma)
            mdl_page[addr[2:1]] = data[3:0];
        else if (!addr[4] && addr[3])
            {mdl_base_count[addr[2:1]], mdl_count[addr[2:1]]} = {data, data};
        else if (!addr[4])
            {mdl_base_addr[addr[2:1]], mdl_cur[addr[2:1]]} = {data, data};
        else if (addr[1])
            mdl_mask[data[1:0]] = data[2];
        else
            {mdl_dec[data[1:0]], mdl_auto[data[1:0]], mdl_to_mem[data[1:0]]} = data[4:2];
    endtask

    // Access with neither select, so no ack and no register change
    task automatic unselected_write(input logic [4:0] addr, input logic [15:0] data);
        next_cycle();
        cpu_access = 1'b1;
        cpu_wr     = 1'b1;
        cpu_addr   = addr;
        cpu_data   = data;
        next_cycle();
        cpu_access = 1'b0;
        cpu_wr     = 1'b0;
    endtask

    task automatic program_channel(input logic [1:0] ch, input logic [15:0] addr,
                                   input logic [15:0] count, input logic [3:0] pg,
                                   input logic to_mem, input logic auto, input logic dec);
        cpu_write(1'b1, {2'b00, ch, 1'b0}, addr);
        cpu_write(1'b1, {2'b01, ch, 1'b0}, count);
        cpu_write(1'b0, {2'b00, ch, 1'b0}, {12'h000, pg});
        cpu_write(1'b1, 5'b10000, {8'h00, 3'b000, dec, auto, to_mem, ch});
    endtask

    task automatic set_mask(input logic [1:0] ch, input logic m);
        cpu_write(1'b1, 5'b10010, {8'h00, 5'b00000, m, ch});
    endtask

    task automatic wait_transfers(input int ch, input int n);
        while (xfers[ch] < n)
            next_cycle();
    endtask

    task automatic wait_idle();
        repeat (2) next_cycle();
        while (req_q.size() != 0 || rd_q.size() != 0 || m_access || m_ack || in_flight != 0)
            next_cycle();
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        {cpu_sel_dma, cpu_sel_page, cpu_access, cpu_wr} = 4'b0000;
        cpu_addr = '0;
        cpu_data = '0;
        dma_req = '0;
        dev_wdata = '0;
        m_rdata = '0;
        m_ack = 1'b0;
        {mdl_base_addr, mdl_base_count, mdl_cur, mdl_count} = '0;
        {mdl_page, mdl_to_mem, mdl_auto, mdl_dec} = '0;
        mdl_mask = 4'hF;
        xfers = '{default: 0};
        ack_due = 1'b0;
        dev_on = '0;
        lfsr = 8'd58;
        bus_busy = 1'b0;
        bus_addr = '0;
        bus_wait = 0;
        in_flight = 0;
        cycles = 0;
        repeat (4) next_cycle();
        reset = 1'b0;

        // All channels masked, requests must be ignored
        dev_on = 4'hF;
        // Mask clear for channel 0 without a select must not land
        unselected_write(5'b10010, 16'h0000);
        repeat (20) next_cycle();
        program_channel(2'd0, 16'h1000, 16'd3, 4'h2, 1'b1, 1'b0, 1'b0);
        program_channel(2'd1, 16'h2005, 16'd2, 4'h5, 1'b0, 1'b0, 1'b1);
        program_channel(2'd2, 16'hFFFE, 16'd2, 4'hA, 1'b0, 1'b0, 1'b0);
        program_channel(2'd3, 16'h0100, 16'd1, 4'hF, 1'b1, 1'b1, 1'b1);
        for (int c = 0; c < 4; c++)
            set_mask(2'(c), 1'b0);

        // Channel 3 reloads, so it runs until its device lets go
        wait_transfers(0, 4);
        wait_transfers(1, 3);
        wait_transfers(2, 3);
        wait_transfers(3, 6);
        dev_on[3] = 1'b0;
        wait_idle();
        repeat (20) next_cycle();
        assert (xfers[0] == 4 && xfers[1] == 3 && xfers[2] == 3)
            else report_error($sformatf("transfer counts %0d %0d %0d after terminal count",
                                        xfers[0], xfers[1], xfers[2]));

        // New page and count on channel 0, then unmask again
        cpu_write(1'b0, 5'b00000, 16'h0007);
        cpu_write(1'b1, 5'b01000, 16'd1);
        set_mask(2'd0, 1'b0);
        wait_transfers(0, 6);
        dev_on = '0;
        wait_idle();
        assert (xfers[0] == 6) else report_error($sformatf("channel 0 made %0d transfers", xfers[0]));

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/dma_pkg.sv
logic/dma_mem_if.sv
logic/dma_channel_regs.sv
logic/dma_transfer_engine.sv
logic/dma_mem_port.sv
logic/dma_unit.sv
tests/dma_unit_checker.sv
tests/dma_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module dma_unit_tb -o dma_sim &&
    ./obj_dir/dma_sim ||
    { echo "DMA simulation failed"; exit 1; }
